/* Bender.yml */
package:
  name: pattern_seq

sources:
  # packages first, then the design bottom up
  - design/seq_cfg_pkg.sv
  - design/seq_step_pkg.sv
  - design/step_table.sv
  - design/step_decoder.sv
  - design/step_executor.sv
  - design/pattern_output.sv
  - design/pattern_seq_top.sv

  - target: simulation
    files:
      - testbench/pattern_seq_assertions.sv
      - testbench/pattern_seq_tb.sv

/* design/pattern_output.sv */
`timescale 1ns/1ps

module pattern_output (
	input logic in_clk,
	input logic in_rst,
	input seq_step_pkg::run_event_t run_event,
	output seq_cfg_pkg::data_t out_data,
	output logic out_busy,
	output logic out_step,
	output logic out_done,
	output logic out_fault,
	output seq_cfg_pkg::step_count_t out_count
);

	// busy rising marks a new run
	logic run_start;

	assign run_start = run_event.busy && !out_busy;

	// --------------------------------------------------
	// data and pulses
	// --------------------------------------------------

	always_ff @(posedge in_clk) begin
		if (in_rst == 1'b1) begin
			out_data <= '0;
			out_busy <= 1'b0;
			out_step <= 1'b0;
			out_done <= 1'b0;
			out_fault <= 1'b0;
		end else begin
			out_busy <= run_event.busy;
			out_step <= run_event.emit;
			out_done <= run_event.finish;
			out_fault <= run_event.fault;

			// data changes only with a step pulse
			if (run_event.emit)
				out_data <= run_event.data;
		end
	end

	// --------------------------------------------------
	// step counter
	// --------------------------------------------------

	always_ff @(posedge in_clk) begin
		if (in_rst == 1'b1) begin
			out_count <= '0;
		end else if (run_start) begin
			out_count <= '0;
		end else if (run_event.emit) begin
			// held after done until the next run
			out_count <= out_count + 1'b1;
		end
	end

endmodule

/* design/pattern_seq_top.sv */
`timescale 1ns/1ps

module pattern_seq_top (
	input logic in_clk,
	input logic in_rst,
	input logic in_enable,
	input logic in_wr_en,
	input seq_cfg_pkg::step_addr_t in_wr_addr,
	input seq_step_pkg::step_word_t in_wr_word,
	output seq_cfg_pkg::data_t out_data,
	output logic out_busy,
	output logic out_step,
	output logic out_done,
	output logic out_fault,
	output seq_cfg_pkg::step_count_t out_count
);

	import seq_cfg_pkg::*;
	import seq_step_pkg::*;

	// fetch path
	step_addr_t rd_addr;
	step_word_t rd_word;
	step_cmd_t cmd;

	// executor to output stage
	run_event_t run_event;

	// --------------------------------------------------
	// program memory and decode
	// --------------------------------------------------

	// busy level locks the table
	step_table u_table (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.wr_en    (in_wr_en),
		.wr_addr  (in_wr_addr),
		.wr_word  (in_wr_word),
		.wr_block (run_event.busy),
		.rd_addr  (rd_addr),
		.rd_word  (rd_word)
	);

	step_decoder u_decoder (
		.word (rd_word),
		.cmd  (cmd)
	);

	// --------------------------------------------------
	// sequencing and outputs
	// --------------------------------------------------

	step_executor u_executor (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.enable    (in_enable),
		.cmd       (cmd),
		.rd_addr   (rd_addr),
		.run_event (run_event)
	);

	pattern_output u_output (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.run_event (run_event),
		.out_data  (out_data),
		.out_busy  (out_busy),
		.out_step  (out_step),
		.out_done  (out_done),
		.out_fault (out_fault),
		.out_count (out_count)
	);

endmodule

/* design/seq_cfg_pkg.sv */
package seq_cfg_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------

	// width of the output word
	localparam int DATA_BITS = 8;
	// hold length or loop repeat count
	localparam int DURATION_BITS = 16;
	// table depth
	localparam int NUM_STEPS = 8;
	localparam int STEP_ADDR_BITS = $clog2(NUM_STEPS);
	// output steps per run
	localparam int COUNT_BITS = 16;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------

	typedef logic [DATA_BITS - 1 : 0] data_t;
	// cycles to hold, or number of jumps
	typedef logic [DURATION_BITS - 1 : 0] duration_t;
	typedef logic [STEP_ADDR_BITS - 1 : 0] step_addr_t;
	typedef logic [COUNT_BITS - 1 : 0] step_count_t;

	// last table entry, nothing follows it
	localparam step_addr_t LAST_STEP = step_addr_t'(NUM_STEPS - 1);

endpackage

/* design/seq_step_pkg.sv */
package seq_step_pkg;

	// --------------------------------------------------
	// table word
	// --------------------------------------------------

	typedef enum logic [1 : 0] {
		OP_OUT  = 2'd0,
		OP_LOOP = 2'd1,
		OP_END  = 2'd2,
		OP_RSVD = 2'd3
	} step_op_t;

	// addr is the word's own index, filled in on read
	typedef struct packed {
		step_op_t               op;
		seq_cfg_pkg::data_t     data;
		seq_cfg_pkg::duration_t duration;
		seq_cfg_pkg::step_addr_t target;
		seq_cfg_pkg::step_addr_t addr;
	} step_word_t;

	// --------------------------------------------------
	// decoded command and run events
	// --------------------------------------------------

	// at most one of the flags, or illegal alone
	typedef struct packed {
		logic                    is_out;
		logic                    is_loop;
		logic                    is_end;
		seq_cfg_pkg::data_t      data;
		seq_cfg_pkg::duration_t  duration;
		seq_cfg_pkg::step_addr_t target;
		logic                    illegal;
	} step_cmd_t;

	typedef struct packed {
		logic               emit;
		seq_cfg_pkg::data_t data;
		logic               finish;
		logic               fault;
		logic               busy;
	} run_event_t;

	typedef enum logic [2 : 0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_HOLD,
		ST_LOOP,
		ST_DONE
	} exec_state_t;

endpackage

/* design/step_decoder.sv */
`timescale 1ns/1ps

module step_decoder (
	input seq_step_pkg::step_word_t word,
	output seq_step_pkg::step_cmd_t cmd
);

	import seq_step_pkg::*;

	// --------------------------------------------------
	// loop target check
	// --------------------------------------------------

	// loops may only jump backwards
	logic target_bad;

	assign target_bad = (word.target >= word.addr);

	// --------------------------------------------------
	// opcode decode
	// --------------------------------------------------

	always_comb begin
		// fields pass through unchanged
		cmd = '0;
		cmd.data = word.data;
		cmd.duration = word.duration;
		cmd.target = word.target;

		case (word.op)
			OP_OUT: begin
				cmd.is_out = 1'b1;
			end

			OP_LOOP: begin
				// forward or self loop ends the run
				if (target_bad) begin
					cmd.illegal = 1'b1;
				end else begin
					cmd.is_loop = 1'b1;
				end
			end

			OP_END: begin
				cmd.is_end = 1'b1;
			end

			OP_RSVD: begin
				cmd.illegal = 1'b1;
			end
		endcase
	end

endmodule

/* design/step_executor.sv */
`timescale 1ns/1ps

module step_executor (
	input logic in_clk,
	input logic in_rst,
	input logic enable,
	input seq_step_pkg::step_cmd_t cmd,
	output seq_cfg_pkg::step_addr_t rd_addr,
	output seq_step_pkg::run_event_t run_event
);

	import seq_cfg_pkg::*;
	import seq_step_pkg::*;

	exec_state_t state;
	exec_state_t next_state;

	// program counter
	step_addr_t pc;
	// remaining hold cycles
	duration_t hold_timer;
	// remaining jumps of the active loop
	duration_t loop_count;
	logic loop_active;
	// run ends on an illegal step
	logic fault_flag;

	logic at_last;
	logic hold_over;
	logic loop_jump;

	// table is read at the program counter
	assign rd_addr = pc;
	assign at_last = (pc == LAST_STEP);
	assign hold_over = (hold_timer == '0);
	// first meeting loads the count, later meetings use it
	assign loop_jump = loop_active ? (loop_count != '0) : (cmd.duration != '0);

	// --------------------------------------------------
	// next state
	// --------------------------------------------------

	always_comb begin
		next_state = state;

		unique case (state)
			ST_IDLE: begin
				// enable only sampled here
				if (enable)
					next_state = ST_FETCH;
			end

			ST_FETCH: begin
				next_state = ST_DECODE;
			end

			ST_DECODE: begin
				if (cmd.illegal || cmd.is_end)
					next_state = ST_DONE;
				else if (cmd.is_loop)
					next_state = ST_LOOP;
				else
					next_state = ST_HOLD;
			end

			ST_HOLD: begin
				// running off the table end stops cleanly
				if (hold_over)
					next_state = at_last ? ST_DONE : ST_FETCH;
			end

			ST_LOOP: begin
				if (loop_jump || !at_last)
					next_state = ST_FETCH;
				else
					next_state = ST_DONE;
			end

			ST_DONE: begin
				next_state = ST_IDLE;
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------

	always_ff @(posedge in_clk) begin
		if (in_rst == 1'b1) begin
			state <= ST_IDLE;
			pc <= '0;
			hold_timer <= '0;
			loop_count <= '0;
			loop_active <= 1'b0;
			fault_flag <= 1'b0;
		end else begin
			state <= next_state;

			unique case (state)
				ST_IDLE: begin
					// fresh run from step zero
					if (enable) begin
						pc <= '0;
						loop_count <= '0;
						loop_active <= 1'b0;
						fault_flag <= 1'b0;
					end
				end

				ST_DECODE: begin
					hold_timer <= cmd.duration;
					fault_flag <= cmd.illegal;
				end

				ST_HOLD: begin
					if (!hold_over)
						hold_timer <= hold_timer - 1'b1;
					else if (!at_last)
						pc <= pc + 1'b1;
				end

				ST_LOOP: begin
					// pc unchanged since decode, so cmd still holds this loop
					if (loop_jump) begin
						pc <= cmd.target;
						loop_count <= (loop_active ? loop_count : cmd.duration) - 1'b1;
						loop_active <= 1'b1;
					end else begin
						// fall through, counter free for the next loop
						loop_count <= '0;
						loop_active <= 1'b0;
						if (!at_last)
							pc <= pc + 1'b1;
					end
				end

				default: begin
				end
			endcase
		end
	end

	// --------------------------------------------------
	// run events
	// --------------------------------------------------

	always_comb begin
		run_event = '0;
		// high from the start cycle, low in the done cycle
		run_event.busy = (state == ST_IDLE) ? enable : (state != ST_DONE);
		run_event.emit = (state == ST_DECODE) && cmd.is_out;
		run_event.data = cmd.data;
		run_event.finish = (state == ST_DONE);
		run_event.fault = (state == ST_DONE) && fault_flag;
	end

endmodule

/* design/step_table.sv */
`timescale 1ns/1ps

module step_table (
	input logic in_clk,
	input logic in_rst,
	input logic wr_en,
	input seq_cfg_pkg::step_addr_t wr_addr,
	input seq_step_pkg::step_word_t wr_word,
	input logic wr_block,
	input seq_cfg_pkg::step_addr_t rd_addr,
	output seq_step_pkg::step_word_t rd_word
);

	import seq_cfg_pkg::*;
	import seq_step_pkg::*;

	// program memory
	step_word_t mem [NUM_STEPS];

	// word at the read address, tagged with its index
	step_word_t fetched;

	always_comb begin
		fetched = mem[rd_addr];
		fetched.addr = rd_addr;
	end

	always_ff @(posedge in_clk) begin
		if (in_rst == 1'b1) begin
			// empty program stops at once
			for (int i = 0; i < NUM_STEPS; i++) begin
				mem[i] <= '{op: OP_END, default: '0};
			end
		end else if (wr_en && !wr_block) begin
			// no loading during a run
			mem[wr_addr] <= wr_word;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge in_clk) begin
		rd_word <= fetched;
	end

endmodule

/* project.f */
design/seq_cfg_pkg.sv
design/seq_step_pkg.sv
design/step_table.sv
design/step_decoder.sv
design/step_executor.sv
design/pattern_output.sv
design/pattern_seq_top.sv
testbench/pattern_seq_assertions.sv
testbench/pattern_seq_tb.sv

/* testbench/pattern_seq_assertions.sv */
`timescale 1ns/1ps

module pattern_seq_assertions (
	input logic in_clk,
	input logic in_rst,
	input seq_cfg_pkg::data_t out_data,
	input logic out_busy,
	input logic out_step,
	input logic out_done,
	input logic out_fault
);

	// --------------------------------------------------
	// output pulse rules
	// --------------------------------------------------

	// a step and the run end never share a cycle
	a_step_done_apart: assert property (@(posedge in_clk) disable iff (in_rst)
		!(out_step && out_done))
		else $error("out_step and out_done high in the same cycle");

	// fault only marks a finishing run
	a_fault_with_done: assert property (@(posedge in_clk) disable iff (in_rst)
		out_fault |-> out_done)
		else $error("out_fault high without out_done");

	// busy already low in the done cycle
	a_done_not_busy: assert property (@(posedge in_clk) disable iff (in_rst)
		out_done |-> !out_busy)
		else $error("out_busy still high with out_done");

	// data word only moves on a step pulse
	a_data_on_step: assert property (@(posedge in_clk) disable iff (in_rst)
		$changed(out_data) |-> out_step)
		else $error("out_data changed without out_step");

endmodule

bind pattern_seq_top pattern_seq_assertions u_assertions (
	.in_clk    (in_clk),
	.in_rst    (in_rst),
	.out_data  (out_data),
	.out_busy  (out_busy),
	.out_step  (out_step),
	.out_done  (out_done),
	.out_fault (out_fault)
);

/* testbench/pattern_seq_tb.sv */
`timescale 1ns/1ps

module pattern_seq_tb;

	import seq_cfg_pkg::*;
	import seq_step_pkg::*;

	// --------------------------------------------------
	// run sizes and watchdog budget
	// --------------------------------------------------

	localparam int CLK_PERIOD = 10;
	localparam int NUM_PROGS = 40;
	localparam int MAX_DUR = 7;
	localparam int MAX_REP = 3;
	// every step repeated by the loop at its longest hold
	localparam int WORST_RUN = NUM_STEPS * (MAX_REP + 1) * (MAX_DUR + 3);
	// plus table load and start
	localparam int RUN_CYCLES = WORST_RUN + 2 * NUM_STEPS + 10;
	// some programs run twice
	localparam int WATCHDOG_CYCLES = NUM_PROGS * 2 * RUN_CYCLES + 200;

	logic in_clk;
	logic in_rst;
	logic in_enable;
	logic in_wr_en;
	step_addr_t in_wr_addr;
	step_word_t in_wr_word;
	data_t out_data;
	logic out_busy;
	logic out_step;
	logic out_done;
	logic out_fault;
	step_count_t out_count;

	// program image as loaded into the table
	step_word_t prog [NUM_STEPS];
	// model results of one run
	data_t exp_data [$];
	duration_t exp_gap [$];
	logic exp_fault;

	int data_errors;
	int count_errors;
	int flag_errors;
	int hold_errors;
	int other_errors;

	pattern_seq_top uut (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.in_enable  (in_enable),
		.in_wr_en   (in_wr_en),
		.in_wr_addr (in_wr_addr),
		.in_wr_word (in_wr_word),
		.out_data   (out_data),
		.out_busy   (out_busy),
		.out_step   (out_step),
		.out_done   (out_done),
		.out_fault  (out_fault),
		.out_count  (out_count)
	);

	initial in_clk = 1'b0;
	always #(CLK_PERIOD / 2) in_clk = ~in_clk;

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			data_errors++;
			$display("Fail %s data: expected %0h, got %0h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input step_count_t exp, input step_count_t act);
		if (act !== exp) begin
			count_errors++;
			$display("Fail %s count: expected %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errors++;
			$display("Fail %s flag: expected %b, got %b", name, exp, act);
		end
	endtask

	// cycles between two step pulses
	task automatic check_hold(input string name, input duration_t exp, input duration_t act);
		if (act !== exp) begin
			hold_errors++;
			$display("Fail %s step gap: expected %0d, got %0d", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// program generation and loading
	// --------------------------------------------------

	function automatic step_word_t random_out();
		step_word_t w;
		w = '0;
		w.op = OP_OUT;
		w.data = data_t'($urandom);
		w.duration = duration_t'($urandom_range(MAX_DUR, 0));
		return w;
	endfunction

	task automatic build_program(input int kind);
		int stop;
		int loop_at;
		for (int a = 0; a < NUM_STEPS; a++)
			prog[a] = random_out();
		case (kind)
			0: begin
				// straight run closed by an end step
				stop = $urandom_range(NUM_STEPS - 2, 0);
				prog[stop].op = OP_END;
			end
			1: begin
				// one backward loop followed by an end step
				loop_at = $urandom_range(NUM_STEPS - 3, 1);
				prog[loop_at].op = OP_LOOP;
				prog[loop_at].target = step_addr_t'($urandom_range(loop_at - 1, 0));
				prog[loop_at].duration = duration_t'($urandom_range(MAX_REP, 0));
				stop = $urandom_range(NUM_STEPS - 1, loop_at + 1);
				prog[stop].op = OP_END;
			end
			2: begin
				stop = $urandom_range(NUM_STEPS - 1, 0);
				prog[stop].op = OP_RSVD;
			end
			default: begin
				// no end step so the run leaves the table
			end
		endcase
	endtask

	task automatic load_program();
		for (int a = 0; a < NUM_STEPS; a++) begin
			@(posedge in_clk);
			in_wr_en <= 1'b1;
			in_wr_addr <= step_addr_t'(a);
			in_wr_word <= prog[a];
		end
		@(posedge in_clk);
		in_wr_en <= 1'b0;
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	task automatic run_model();
		int pc;
		int cnt;
		int gap;
		bit active;
		step_word_t w;
		exp_data.delete();
		exp_gap.delete();
		exp_fault = 1'b0;
		pc = 0;
		cnt = 0;
		gap = 0;
		active = 1'b0;
		for (int guard = 0; guard < 1000; guard++) begin
			w = prog[pc];
			if (w.op == OP_OUT) begin
				if (exp_data.size() > 0)
					exp_gap.push_back(duration_t'(gap));
				exp_data.push_back(w.data);
				// hold plus fetch and decode of the next step
				gap = w.duration + 3;
				if (pc == NUM_STEPS - 1)
					break;
				pc++;
			end else if (w.op == OP_LOOP && w.target < pc) begin
				// fetch, decode and the loop cycle
				gap += 3;
				// repeat count taken on the first meeting of the loop
				if (!active) begin
					cnt = int'(w.duration);
					active = 1'b1;
				end
				if (cnt > 0) begin
					cnt--;
					pc = int'(w.target);
				end else begin
					// repeats used up so fall through
					active = 1'b0;
					if (pc == NUM_STEPS - 1)
						break;
					pc++;
				end
			end else begin
				// end step, reserved step or forward loop
				exp_fault = (w.op != OP_END);
				break;
			end
		end
	endtask

	// --------------------------------------------------
	// one run against the model
	// --------------------------------------------------

	task automatic run_and_check(input string name, input bit scribble, input bit poke);
		int idx;
		int since;
		bit poked;
		data_t prev_data;
		step_word_t junk;
		idx = 0;
		since = 0;
		poked = 1'b0;
		prev_data = out_data;
		@(posedge in_clk);
		in_enable <= 1'b1;
		do
			@(posedge in_clk);
		while (!out_busy);
		in_enable <= 1'b0;
		if (scribble) begin
			// table locked by now so step zero must survive
			junk = prog[0];
			junk.op = OP_OUT;
			junk.data = ~prog[0].data;
			in_wr_en <= 1'b1;
			in_wr_addr <= '0;
			in_wr_word <= junk;
		end
		forever begin
			@(posedge in_clk);
			since++;
			in_wr_en <= 1'b0;
			in_enable <= 1'b0;
			if (!out_step && out_data !== prev_data) begin
				other_errors++;
				$display("%s: out_data changed without a step pulse", name);
			end
			prev_data = out_data;
			if (out_step) begin
				if (idx >= exp_data.size()) begin
					other_errors++;
					$display("%s: more output steps than the model gives", name);
				end else begin
					check_data(name, exp_data[idx], out_data);
					if (idx > 0)
						check_hold(name, exp_gap[idx - 1], duration_t'(since));
				end
				idx++;
				since = 0;
				// second start mid run must not restart
				if (poke && !poked) begin
					in_enable <= 1'b1;
					poked = 1'b1;
				end
			end
			if (out_done) begin
				if (idx != exp_data.size()) begin
					other_errors++;
					$display("%s: run ended before all expected steps", name);
				end
				check_flag(name, exp_fault, out_fault);
				check_count(name, step_count_t'(exp_data.size()), out_count);
				break;
			end
		end
		// back in idle and staying there
		@(posedge in_clk);
		@(posedge in_clk);
		check_flag({name, " idle"}, 1'b0, out_busy);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		string name;
		int kind;
		data_errors = 0;
		count_errors = 0;
		flag_errors = 0;
		hold_errors = 0;
		other_errors = 0;
		void'($urandom(97));
		in_rst = 1'b1;
		in_enable = 1'b0;
		in_wr_en = 1'b0;
		in_wr_addr = '0;
		in_wr_word = '0;
		repeat (3) @(posedge in_clk);
		in_rst <= 1'b0;
		@(posedge in_clk);
		// outputs idle after reset
		check_data("reset", '0, out_data);
		check_count("reset", '0, out_count);
		check_flag("reset busy", 1'b0, out_busy);
		check_flag("reset step", 1'b0, out_step);
		check_flag("reset done", 1'b0, out_done);
		check_flag("reset fault", 1'b0, out_fault);
		// cleared table stops at once
		for (int a = 0; a < NUM_STEPS; a++)
			prog[a] = '{op: OP_END, default: '0};
		run_model();
		run_and_check("reset table", 1'b0, 1'b0);
		for (int p = 0; p < NUM_PROGS; p++) begin
			kind = p % 4;
			name = $sformatf("prog %0d kind %0d", p, kind);
			build_program(kind);
			load_program();
			run_model();
			run_and_check(name, (p % 5) == 4, (p % 2) == 1);
			// same program again to show the blocked write left no trace
			if ((p % 5) == 4)
				run_and_check({name, " rerun"}, 1'b0, 1'b0);
		end
		$display("errors: data %0d, count %0d, flag %0d, hold %0d, other %0d",
			data_errors, count_errors, flag_errors, hold_errors, other_errors);
		if (data_errors + count_errors + flag_errors + hold_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// hard stop for a hung run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the last program finished");
		$display(">>> FAIL");
		$finish;
	end

endmodule
